//--- design/cpu_pkg.sv
// ISA-level definitions for the 32-bit MIPS-style pipeline
// Word and register types, execute control field layout and the
// instruction-field constants that the execute stage decodes
`default_nettype none

package cpu_pkg;

	// -------------------------------------------------------------------------
	// Basic ISA types
	// -------------------------------------------------------------------------
	typedef logic [31:0] word_t;       // Data word
	typedef logic [4:0]  reg_addr_t;   // Register number, r0 hardwired to zero
	typedef logic [5:0]  funct_t;      // R-type function code, imm[5:0]
	typedef logic [5:0]  ex_ctrl_t;    // Execute control from decode
	typedef logic [3:0]  alu_op_t;     // Main ALU op, ex_ctrl[4:1]

	// Bit positions inside ex_ctrl_t
	localparam int EX_IMM_SEL = 0;     // Immediate as operand B
	localparam int EX_RD_SEL  = 5;     // rd as destination

	// Main ALU op values
	localparam alu_op_t ALUOP_ADD  = 4'd0;
	localparam alu_op_t ALUOP_SUB  = 4'd1;
	localparam alu_op_t ALUOP_RTYP = 4'd2;  // Look at funct
	localparam alu_op_t ALUOP_AND  = 4'd3;
	localparam alu_op_t ALUOP_OR   = 4'd4;
	localparam alu_op_t ALUOP_SLT  = 4'd5;
	localparam alu_op_t ALUOP_LUI  = 4'd6;
	localparam alu_op_t ALUOP_ADDI = 4'd7;

	// Whole-field encodings with a special meaning
	localparam ex_ctrl_t EX_LINK  = 6'b001110;  // Jump-and-link
	localparam ex_ctrl_t EX_RTYPE = 6'b100100;  // Register-type ALU instruction

	// Function codes
	localparam funct_t FUNCT_ADD       = 6'd32;  // Trapping add
	localparam funct_t FUNCT_SUB       = 6'd34;  // Trapping subtract
	localparam funct_t FUNCT_SHAMT_MAX = 6'd3;   // At or below, shift by shamt

	// Return address offset past the delay slot
	localparam word_t LINK_OFFSET = 32'd8;

endpackage

`default_nettype wire

//--- design/exec_pkg.sv
// Execute-stage definitions
// ALU control codes, forwarding selection and the control fields
// that ride along to the memory and write-back stages
`default_nettype none

package exec_pkg;

	// -------------------------------------------------------------------------
	// ALU control code
	// -------------------------------------------------------------------------
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		NOR = 4'd5,
		SLT = 4'd6,   // Unsigned compare
		SLL = 4'd10,
		SRL = 4'd11,
		SRA = 4'd12,
		LUI = 4'd13,  // Upper immediate
		BAD = 4'd15   // Undefined op, result forced to zero
	} alu_ctrl_t;

	// Source of a forwarded operand
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,  // Register file value
		FWD_WB   = 2'd1,  // Write-back stage
		FWD_MEM  = 2'd2   // EX/MEM register
	} fwd_sel_t;

	// -------------------------------------------------------------------------
	// Later-stage control fields
	// -------------------------------------------------------------------------
	typedef logic [2:0] mem_ctrl_t;  // Memory stage, not decoded here
	typedef logic [1:0] wb_ctrl_t;   // Write-back stage

	localparam int WB_REG_WRITE = 1;  // reg_write bit of wb_ctrl_t

endpackage

`default_nettype wire

//--- design/operand_forward.sv
// Operand forwarding and selection
// Detects RAW hazards against the EX/MEM and write-back stages,
// forwards the newest value and builds ALU operands A and B
// plus the store data
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
	input  wire cpu_pkg::reg_addr_t rs,
	input  wire cpu_pkg::reg_addr_t rt,
	input  wire cpu_pkg::reg_addr_t rd_mem,
	input  wire cpu_pkg::reg_addr_t rd_wb,
	input  wire                     reg_write_mem,
	input  wire                     reg_write_wb,
	input  wire cpu_pkg::word_t     data_1,
	input  wire cpu_pkg::word_t     data_2,
	input  wire cpu_pkg::word_t     imm,
	input  wire cpu_pkg::word_t     pc,
	input  wire cpu_pkg::word_t     res_mem,
	input  wire cpu_pkg::word_t     write_data_wb,
	input  wire cpu_pkg::ex_ctrl_t  ex_ctrl,
	output cpu_pkg::word_t          op_a,
	output cpu_pkg::word_t          op_b,
	output cpu_pkg::word_t          store_data
);

	import cpu_pkg::*;
	import exec_pkg::*;

	fwd_sel_t sel_a;      // Forward source for rs
	fwd_sel_t sel_b;      // Forward source for rt
	word_t    fwd_rs;     // Newest rs value
	word_t    fwd_rt;     // Newest rt value
	funct_t   funct;
	logic     is_link;
	logic     is_shamt;   // Shift by the shamt field

	// Hazard detection, EX/MEM has priority over write-back
	// r0 always reads as zero so it never takes a forwarded value
	function automatic fwd_sel_t pick_src(input reg_addr_t src);
		fwd_sel_t sel;
		sel = FWD_NONE;
		if (reg_write_mem && (rd_mem != '0) && (rd_mem == src))
			sel = FWD_MEM;
		else if (reg_write_wb && (rd_wb != '0) && (rd_wb == src))
			sel = FWD_WB;
		return sel;
	endfunction

	function automatic word_t fwd_value(input fwd_sel_t sel, input word_t reg_val);
		word_t val;
		case (sel)
			FWD_MEM: val = res_mem;
			FWD_WB:  val = write_data_wb;
			default: val = reg_val;
		endcase
		return val;
	endfunction

	always_comb
	begin
		sel_a  = pick_src(rs);
		sel_b  = pick_src(rt);
		fwd_rs = fwd_value(sel_a, data_1);
		fwd_rt = fwd_value(sel_b, data_2);
	end

	assign funct    = imm[5:0];
	assign is_link  = (ex_ctrl == EX_LINK);
	assign is_shamt = (ex_ctrl == EX_RTYPE) && (funct <= FUNCT_SHAMT_MAX);

	// -------------------------------------------------------------------------
	// Operand selection
	// -------------------------------------------------------------------------
	always_comb
	begin
		if (is_link)
			op_a = pc;                          // Return address base
		else if (is_shamt)
			op_a = {27'b0, imm[10:6]};          // shamt field
		else
			op_a = fwd_rs;

		if (is_link)
			op_b = LINK_OFFSET;
		else if (ex_ctrl[EX_IMM_SEL])
			op_b = imm;                         // Sign-extended by decode
		else
			op_b = fwd_rt;
	end

	assign store_data = fwd_rt;  // Store data also needs forwarding

endmodule

`default_nettype wire

//--- design/alu_control.sv
// ALU control decode
// Maps the main ALU op from decode and the R-type funct code to
// the control code the ALU runs
`timescale 1ns/1ps
`default_nettype none

module alu_control (
	input  wire cpu_pkg::alu_op_t alu_op,
	input  wire cpu_pkg::funct_t  funct,
	output exec_pkg::alu_ctrl_t   alu_ctrl
);

	import cpu_pkg::*;
	import exec_pkg::*;

	alu_ctrl_t rtype_ctrl;  // Decode of funct alone

	// -------------------------------------------------------------------------
	// R-type funct decode
	// -------------------------------------------------------------------------
	always_comb
	begin
		case (funct)
			6'd0, 6'd4: rtype_ctrl = SLL;   // sll, sllv
			6'd2, 6'd6: rtype_ctrl = SRL;   // srl, srlv
			6'd3, 6'd7: rtype_ctrl = SRA;   // sra, srav
			FUNCT_ADD:  rtype_ctrl = ADD;
			6'd33:      rtype_ctrl = ADD;   // addu, no trap
			FUNCT_SUB:  rtype_ctrl = SUB;
			6'd36:      rtype_ctrl = AND;
			6'd37:      rtype_ctrl = OR;
			6'd38:      rtype_ctrl = XOR;
			6'd39:      rtype_ctrl = NOR;
			6'd42:      rtype_ctrl = SLT;
			default:    rtype_ctrl = BAD;   // Undefined funct
		endcase
	end

	// -------------------------------------------------------------------------
	// Main op decode
	// -------------------------------------------------------------------------
	always_comb
	begin
		case (alu_op)
			ALUOP_ADD:  alu_ctrl = ADD;         // Loads and stores
			ALUOP_SUB:  alu_ctrl = SUB;         // Branch compare
			ALUOP_RTYP: alu_ctrl = rtype_ctrl;
			ALUOP_AND:  alu_ctrl = AND;
			ALUOP_OR:   alu_ctrl = OR;
			ALUOP_SLT:  alu_ctrl = SLT;
			ALUOP_LUI:  alu_ctrl = LUI;
			ALUOP_ADDI: alu_ctrl = ADD;
			default:    alu_ctrl = BAD;
		endcase
	end

endmodule

`default_nettype wire

//--- design/alu.sv
// 32-bit ALU
// Arithmetic, logic and shift operations with a zero flag and a
// signed-overflow flag for the trapping add and subtract
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire cpu_pkg::word_t       op_a,
	input  wire cpu_pkg::word_t       op_b,
	input  wire exec_pkg::alu_ctrl_t  alu_ctrl,
	input  wire cpu_pkg::funct_t      funct,
	input  wire                       rtype,
	output cpu_pkg::word_t            result,
	output logic                      zero,
	output logic                      overflow
);

	import cpu_pkg::*;
	import exec_pkg::*;

	word_t      sum;
	word_t      diff;
	logic [4:0] shamt;     // Shift distance
	logic       add_ovf;
	logic       sub_ovf;

	assign sum   = op_a + op_b;
	assign diff  = op_a - op_b;
	assign shamt = op_a[4:0];

	// -------------------------------------------------------------------------
	// Result mux
	// -------------------------------------------------------------------------
	always_comb
	begin
		case (alu_ctrl)
			ADD:     result = sum;
			SUB:     result = diff;
			AND:     result = op_a & op_b;
			OR:      result = op_a | op_b;
			XOR:     result = op_a ^ op_b;
			NOR:     result = ~(op_a | op_b);
			SLT:     result = (op_a < op_b) ? 32'd1 : 32'd0;  // Unsigned
			SLL:     result = op_b << shamt;
			SRL:     result = op_b >> shamt;
			SRA:     result = $signed(op_b) >>> shamt;       // Sign fill
			LUI:     result = op_b << 16;
			default: result = '0;                             // BAD
		endcase
	end

	assign zero = (result == '0);

	// Same-sign inputs giving an opposite-sign sum
	assign add_ovf = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
	// Different-sign inputs, difference takes the sign of op_b
	assign sub_ovf = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);

	// Only add and sub trap, addu and immediates never flag
	always_comb
	begin
		overflow = 1'b0;
		if (rtype && (funct == FUNCT_ADD))
			overflow = add_ovf;
		else if (rtype && (funct == FUNCT_SUB))
			overflow = sub_ovf;
	end

endmodule

`default_nettype wire

//--- design/ex_mem_latch.sv
// EX/MEM pipeline register
// Chooses the destination register, kills control of flushed
// instructions and registers the stage results
`timescale 1ns/1ps
`default_nettype none

module ex_mem_latch (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      flush_ex,
	input  wire cpu_pkg::reg_addr_t  rt,
	input  wire cpu_pkg::reg_addr_t  rd,
	input  wire cpu_pkg::ex_ctrl_t   ex_ctrl,
	input  wire cpu_pkg::word_t      result,
	input  wire                      zero,
	input  wire                      overflow,
	input  wire cpu_pkg::word_t      store_data,
	input  wire exec_pkg::mem_ctrl_t mem_ctrl_ex,
	input  wire exec_pkg::wb_ctrl_t  wb_ctrl_ex,
	output cpu_pkg::word_t           res_mem,
	output cpu_pkg::word_t           store_data_mem,
	output logic                     zero_mem,
	output logic                     over_mem,
	output cpu_pkg::reg_addr_t       write_reg_mem,
	output exec_pkg::mem_ctrl_t      mem_ctrl_mem,
	output exec_pkg::wb_ctrl_t       wb_ctrl_mem
);

	import cpu_pkg::*;
	import exec_pkg::*;

	reg_addr_t write_reg;  // Destination chosen this cycle

	// Link writes the return address to rd
	assign write_reg = ((ex_ctrl == EX_LINK) || ex_ctrl[EX_RD_SEL]) ? rd : rt;

	// -------------------------------------------------------------------------
	// Pipeline register
	// -------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			res_mem        <= '0;
			store_data_mem <= '0;
			zero_mem       <= 1'b0;
			over_mem       <= 1'b0;
			write_reg_mem  <= '0;
			mem_ctrl_mem   <= '0;   // No memory access
			wb_ctrl_mem    <= '0;   // No register write
		end
		else
		begin
			res_mem        <= result;
			store_data_mem <= store_data;
			zero_mem       <= zero;
			over_mem       <= overflow;
			write_reg_mem  <= write_reg;
			mem_ctrl_mem   <= flush_ex ? '0 : mem_ctrl_ex;  // Bubble
			wb_ctrl_mem    <= flush_ex ? '0 : wb_ctrl_ex;
		end
	end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
// Execute stage of the five-stage pipeline
// Forwarding, ALU decode and ALU work side by side on the ID/EX
// instruction, the EX/MEM register captures the result one cycle later
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire                      clk,
	input  wire                      reset,
	input  wire cpu_pkg::word_t      pc,
	input  wire cpu_pkg::word_t      data_1,
	input  wire cpu_pkg::word_t      data_2,
	input  wire cpu_pkg::word_t      imm,
	input  wire cpu_pkg::reg_addr_t  rs,
	input  wire cpu_pkg::reg_addr_t  rt,
	input  wire cpu_pkg::reg_addr_t  rd,
	input  wire cpu_pkg::ex_ctrl_t   ex_ctrl,
	input  wire exec_pkg::mem_ctrl_t mem_ctrl_ex,
	input  wire exec_pkg::wb_ctrl_t  wb_ctrl_ex,
	input  wire                      flush_ex,
	input  wire cpu_pkg::reg_addr_t  rd_wb,
	input  wire                      reg_write_wb,
	input  wire cpu_pkg::word_t      write_data_wb,
	output cpu_pkg::word_t           res_mem,
	output logic                     zero_mem,
	output logic                     over_mem,
	output cpu_pkg::reg_addr_t       write_reg_mem,
	output cpu_pkg::word_t           store_data_mem,
	output exec_pkg::mem_ctrl_t      mem_ctrl_mem,
	output exec_pkg::wb_ctrl_t       wb_ctrl_mem
);

	import cpu_pkg::*;
	import exec_pkg::*;

	word_t     op_a, op_b, store_data, result;
	alu_ctrl_t alu_ctrl;
	alu_op_t   alu_op;
	funct_t    funct;
	logic      rtype;          // rd destination marks register-type
	logic      zero, overflow;
	logic      reg_write_mem;  // EX/MEM stage writes a register

	assign alu_op        = ex_ctrl[4:1];
	assign funct         = imm[5:0];
	assign rtype         = ex_ctrl[EX_RD_SEL];
	assign reg_write_mem = wb_ctrl_mem[WB_REG_WRITE];

	operand_forward u_fwd (.rs(rs), .rt(rt), .rd_mem(write_reg_mem), .rd_wb(rd_wb),
		.reg_write_mem(reg_write_mem), .reg_write_wb(reg_write_wb), .data_1(data_1),
		.data_2(data_2), .imm(imm), .pc(pc), .res_mem(res_mem),
		.write_data_wb(write_data_wb), .ex_ctrl(ex_ctrl), .op_a(op_a), .op_b(op_b),
		.store_data(store_data));

	alu_control u_alu_ctrl (.alu_op(alu_op), .funct(funct), .alu_ctrl(alu_ctrl));

	alu u_alu (.op_a(op_a), .op_b(op_b), .alu_ctrl(alu_ctrl), .funct(funct),
		.rtype(rtype), .result(result), .zero(zero), .overflow(overflow));

	ex_mem_latch u_latch (.clk(clk), .reset(reset), .flush_ex(flush_ex), .rt(rt),
		.rd(rd), .ex_ctrl(ex_ctrl), .result(result), .zero(zero),
		.overflow(overflow), .store_data(store_data), .mem_ctrl_ex(mem_ctrl_ex),
		.wb_ctrl_ex(wb_ctrl_ex), .res_mem(res_mem), .store_data_mem(store_data_mem),
		.zero_mem(zero_mem), .over_mem(over_mem), .write_reg_mem(write_reg_mem),
		.mem_ctrl_mem(mem_ctrl_mem), .wb_ctrl_mem(wb_ctrl_mem));

endmodule

`default_nettype wire

//--- tests/tb_execute_checks.svh
// Execute stage testbench helpers
// Typed compare tasks plus the input drive helpers, included inside
// the testbench module so they see its signals and counters
`ifndef TB_EXECUTE_CHECKS_SVH
`define TB_EXECUTE_CHECKS_SVH

// ---------------------------------------------------------------------------
// Compare tasks
// ---------------------------------------------------------------------------
task automatic record_check(input logic ok, input string msg);
	checks++;
	if (!ok)
	begin
		errors++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	end
endtask

task automatic check_word(input string what, input word_t got, input word_t exp);
	record_check(got === exp, $sformatf("%s is %h, expected %h", what, got, exp));
endtask

task automatic check_reg_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
	record_check(got === exp, $sformatf("%s is r%0d, expected r%0d", what, got, exp));
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
	record_check(got === exp, $sformatf("%s is %b, expected %b", what, got, exp));
endtask

task automatic check_mem_ctrl(input string what, input mem_ctrl_t got, input mem_ctrl_t exp);
	record_check(got === exp, $sformatf("%s is %b, expected %b", what, got, exp));
endtask

task automatic check_wb_ctrl(input string what, input wb_ctrl_t got, input wb_ctrl_t exp);
	record_check(got === exp, $sformatf("%s is %b, expected %b", what, got, exp));
endtask

// Result, zero flag, overflow and destination of one instruction
task automatic check_result(input string what, input word_t exp, input reg_addr_t dest,
	input logic ovf);
	check_word({what, " result"}, res_mem, exp);
	check_flag({what, " zero"}, zero_mem, exp == '0);
	check_flag({what, " overflow"}, over_mem, ovf);
	check_reg_addr({what, " dest"}, write_reg_mem, dest);
endtask

// ---------------------------------------------------------------------------
// Drive helpers, called right after a falling edge
// ---------------------------------------------------------------------------
task automatic clear_inputs();
	pc            = '0;
	data_1        = '0;
	data_2        = '0;
	imm           = '0;
	rs            = '0;
	rt            = '0;
	rd            = '0;
	ex_ctrl       = '0;
	mem_ctrl_ex   = '0;
	wb_ctrl_ex    = '0;   // No register write, nothing to forward later
	flush_ex      = 1'b0;
	rd_wb         = '0;
	reg_write_wb  = 1'b0;
	write_data_wb = '0;
endtask

// Register-type instruction, shamt field left at zero
task automatic set_rtype(input funct_t f, input reg_addr_t s, input reg_addr_t t,
	input reg_addr_t d, input word_t a, input word_t b);
	ex_ctrl = EX_RTYPE;
	imm     = {26'b0, f};
	rs      = s;
	rt      = t;
	rd      = d;
	data_1  = a;
	data_2  = b;
endtask

// Outputs then show the instruction driven before the call
task automatic next_cycle();
	@(negedge clk);
endtask

`endif

//--- tests/tb_execute_stage.sv
// Execute stage testbench
// Directed tests for R-type and immediate ops, forwarding, flags,
// jump-and-link, reset and flush
`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage;

	import cpu_pkg::*;
	import exec_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_TESTS    = 6;
	localparam int TEST_CYCLES  = 20;   // Watchdog budget per test

	logic      clk, reset, flush_ex, reg_write_wb;
	word_t     pc, data_1, data_2, imm, write_data_wb;
	reg_addr_t rs, rt, rd, rd_wb;
	ex_ctrl_t  ex_ctrl;
	mem_ctrl_t mem_ctrl_ex, mem_ctrl_mem;
	wb_ctrl_t  wb_ctrl_ex, wb_ctrl_mem;
	word_t     res_mem, store_data_mem;
	logic      zero_mem, over_mem;
	reg_addr_t write_reg_mem;

	int     errors    = 0;
	int     checks    = 0;
	int     tests_run = 0;
	integer seed      = 60;   // Operand stream

	`include "tb_execute_checks.svh"

	execute_stage UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Reference R-type result, a is rs or the shamt field
	function automatic word_t rtype_expect(input funct_t f, input word_t a, input word_t b);
		case (f)
			6'd0, 6'd4:   return b << a[4:0];
			6'd2, 6'd6:   return b >> a[4:0];
			6'd3, 6'd7:   return word_t'($signed(b) >>> a[4:0]);
			6'd32, 6'd33: return a + b;
			6'd34:        return a - b;
			6'd36:        return a & b;
			6'd37:        return a | b;
			6'd38:        return a ^ b;
			6'd39:        return ~(a | b);
			6'd42:        return (a < b) ? 32'd1 : 32'd0;   // Unsigned
			default:      return '0;
		endcase
	endfunction

	// Signed overflow, 33-bit result no longer fits in 32 bits
	function automatic logic signed_overflow(input logic subtract, input word_t a,
		input word_t b);
		logic signed [32:0] wide;
		if (subtract)
			wide = $signed({a[31], a}) - $signed({b[31], b});
		else
			wide = $signed({a[31], a}) + $signed({b[31], b});
		return wide[32] != wide[31];
	endfunction

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		$display("%s done, %0d errors", name, errors - errs_before);
	endtask

	// -------------------------------------------------------------------------
	// Directed tests
	// -------------------------------------------------------------------------
	task automatic test_rtype();
		funct_t functs[15] = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd32, 6'd33,
			6'd34, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd50};   // Last one undefined
		word_t      a, b;
		logic [4:0] sh;
		logic       exp_ovf;
		for (int i = 0; i < 15; i++)
		begin
			a  = $random(seed);
			b  = $random(seed);
			sh = i[4:0] + 5'd1;
			case (functs[i])
				6'd32:   exp_ovf = signed_overflow(1'b0, a, b);
				6'd34:   exp_ovf = signed_overflow(1'b1, a, b);
				default: exp_ovf = 1'b0;   // Only add and sub trap
			endcase
			set_rtype(functs[i], 5'd1, 5'd2, 5'd3, a, b);
			imm[10:6] = sh;
			next_cycle();
			check_result($sformatf("funct %0d", functs[i]),
				rtype_expect(functs[i], (functs[i] <= 6'd3) ? {27'b0, sh} : a, b), 5'd3,
				exp_ovf);
			check_word("R-type store data", store_data_mem, b);
		end
	endtask

	task automatic test_immediate();
		alu_op_t op;
		word_t   a, exp_val;
		for (int i = 0; i < 9; i++)
		begin
			op      = (i == 8) ? ALUOP_SLT : alu_op_t'(i);
			a       = (i == 8) ? 32'hFFFF_FFF0 : $random(seed);  // Signed would say less
			ex_ctrl = {1'b0, op, 1'b1};
			rs      = 5'd4;
			rt      = 5'd9;
			rd      = 5'd12;
			data_1  = a;
			imm     = (i == 8) ? 32'd1 : $random(seed);
			case (op)
				ALUOP_SUB:  exp_val = a - imm;
				ALUOP_RTYP: exp_val = rtype_expect(imm[5:0], a, imm);
				ALUOP_AND:  exp_val = a & imm;
				ALUOP_OR:   exp_val = a | imm;
				ALUOP_SLT:  exp_val = (a < imm) ? 32'd1 : 32'd0;
				ALUOP_LUI:  exp_val = imm << 16;
				default:    exp_val = a + imm;               // add and addi
			endcase
			next_cycle();
			check_result($sformatf("immediate op %0d", op), exp_val, 5'd9, 1'b0);
		end
	endtask

	task automatic test_forwarding();
		set_rtype(6'd33, 5'd1, 5'd2, 5'd5, 32'd10, 32'd20);   // r5 = 30
		wb_ctrl_ex = 2'b10;
		next_cycle();
		check_result("producer", 32'd30, 5'd5, 1'b0);
		set_rtype(6'd33, 5'd5, 5'd5, 5'd6, 32'd999, 32'd888);  // Both stages hold r5
		rd_wb         = 5'd5;
		reg_write_wb  = 1'b1;
		write_data_wb = 32'd777;
		next_cycle();
		check_result("EX/MEM priority", 32'd60, 5'd6, 1'b0);
		check_word("forwarded store data", store_data_mem, 32'd30);
		set_rtype(6'd33, 5'd5, 5'd7, 5'd0, 32'd999, 32'd4);    // r5 now only in write-back
		write_data_wb = 32'd30;
		next_cycle();
		check_result("write-back forward", 32'd34, 5'd0, 1'b0);
		set_rtype(6'd33, 5'd0, 5'd0, 5'd8, 32'd0, 32'd0);      // r0 written in both stages
		wb_ctrl_ex    = 2'b00;
		rd_wb         = 5'd0;
		write_data_wb = 32'd555;
		next_cycle();
		check_result("r0 not forwarded", 32'd0, 5'd8, 1'b0);
	endtask

	task automatic test_flags();
		set_rtype(6'd32, 5'd1, 5'd2, 5'd3, 32'h7FFF_FFFF, 32'd1);
		next_cycle();
		check_result("add overflow", 32'h8000_0000, 5'd3, 1'b1);
		set_rtype(6'd33, 5'd1, 5'd2, 5'd3, 32'h7FFF_FFFF, 32'd1);
		next_cycle();
		check_result("addu no trap", 32'h8000_0000, 5'd3, 1'b0);
		ex_ctrl = {1'b0, ALUOP_ADD, 1'b1};
		imm     = 32'd1;
		next_cycle();
		check_result("immediate add no trap", 32'h8000_0000, 5'd2, 1'b0);
		imm = 32'd32;             // Low bits alias the trapping add code
		next_cycle();
		check_result("immediate add, add funct bits", 32'h8000_001F, 5'd2, 1'b0);
		set_rtype(6'd34, 5'd1, 5'd2, 5'd3, 32'h8000_0000, 32'd1);
		next_cycle();
		check_result("sub overflow", 32'h7FFF_FFFF, 5'd3, 1'b1);
		set_rtype(6'd34, 5'd1, 5'd2, 5'd3, 32'h1234_5678, 32'h1234_5678);
		next_cycle();
		check_result("sub to zero", 32'd0, 5'd3, 1'b0);
	endtask

	task automatic test_link();
		word_t ret_pc;
		ret_pc = $random(seed) & 32'hFFFF_FFFC;
		set_rtype(6'd33, 5'd1, 5'd2, 5'd31, 32'd5, 32'd6);
		ex_ctrl       = EX_LINK;
		pc            = ret_pc;
		wb_ctrl_ex    = 2'b10;
		rd_wb         = 5'd1;   // rs hazard must not matter
		reg_write_wb  = 1'b1;
		write_data_wb = 32'hDEAD_0000;
		next_cycle();
		check_result("jump-and-link", ret_pc + 32'd8, 5'd31, 1'b0);
	endtask

	task automatic test_reset_flush();
		set_rtype(6'd37, 5'd1, 5'd2, 5'd3, 32'h0F0F_0000, 32'h0000_00F0);
		mem_ctrl_ex = 3'b101;
		wb_ctrl_ex  = 2'b11;
		reset       = 1'b1;
		next_cycle();
		check_mem_ctrl("mem_ctrl after reset", mem_ctrl_mem, '0);
		check_wb_ctrl("wb_ctrl after reset", wb_ctrl_mem, '0);
		check_word("result after reset", res_mem, '0);
		reset = 1'b0;
		next_cycle();
		check_mem_ctrl("mem_ctrl pass", mem_ctrl_mem, 3'b101);
		check_wb_ctrl("wb_ctrl pass", wb_ctrl_mem, 2'b11);
		flush_ex = 1'b1;          // Same instruction as a bubble
		next_cycle();
		check_mem_ctrl("mem_ctrl flushed", mem_ctrl_mem, '0);
		check_wb_ctrl("wb_ctrl flushed", wb_ctrl_mem, '0);
		check_result("flushed", 32'h0F0F_00F0, 5'd3, 1'b0);
		flush_ex = 1'b0;
	endtask

	// -------------------------------------------------------------------------
	// Test sequence
	// -------------------------------------------------------------------------
	initial
	begin
		int start;
		clear_inputs();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		start = errors;
		test_rtype();
		finish_test("R-type operations", start);
		start = errors;
		clear_inputs();
		test_immediate();
		finish_test("Immediate operations", start);
		start = errors;
		clear_inputs();
		test_forwarding();
		finish_test("Forwarding", start);
		start = errors;
		clear_inputs();
		test_flags();
		finish_test("Flags", start);
		start = errors;
		clear_inputs();
		test_link();
		finish_test("Jump-and-link", start);
		start = errors;
		clear_inputs();
		test_reset_flush();
		finish_test("Reset and flush", start);
		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog
	initial
	begin
		#((RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD);
		$display("Timeout: the test sequence did not finish in time");
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+tests
design/cpu_pkg.sv
design/exec_pkg.sv
design/operand_forward.sv
design/alu_control.sv
design/alu.sv
design/ex_mem_latch.sv
design/execute_stage.sv
tests/tb_execute_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f build.f --top-module tb_execute_stage -Mdir obj_dir

./obj_dir/Vtb_execute_stage | tee "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	echo "Simulation FAILED, see $LOG"
	exit 1
fi

echo "Simulation passed"
